// File: Bender.yml
package:
  name: cpuCore

sources:
  - source/cpuPkg.sv
  - source/cpuBuses.sv
  - source/instrDecoder.sv
  - source/aluExecute.sv
  - source/archState.sv
  - source/busSequencer.sv
  - source/cpuCore.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_cpuCore.sv

// File: source/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
    ctrlBus.execute ctrl,
    resultBus.execute res,
    input cpuPkg::word_t regA,
    input cpuPkg::word_t regB,
    input cpuPkg::word_t regC,
    input cpuPkg::word_t pc,
    input cpuPkg::flags_t flags
);

    cpuPkg::word_t opA;
    cpuPkg::word_t opB;
    cpuPkg::word_t aluOut;
    logic [cpuPkg::dataWidth:0] wide;  // Extra bit for carry and borrow
    logic carry;
    logic overflow;
    logic aluClass;
    logic taken;

    function automatic cpuPkg::word_t readReg(input cpuPkg::regIdx_t idx,
                                              input cpuPkg::word_t a,
                                              input cpuPkg::word_t b,
                                              input cpuPkg::word_t c);
        case (idx)
            2'd1: return a;
            2'd2: return b;
            2'd3: return c;
            default: return '0;
        endcase
    endfunction

    assign opA = readReg(ctrl.srcA, regA, regB, regC);
    assign opB = ctrl.useImm ? ctrl.imm : readReg(ctrl.srcB, regA, regB, regC);

    always_comb begin
        wide = '0;
        carry = 1'b0;
        overflow = 1'b0;
        case (ctrl.aluOp)
            cpuPkg::ADD: begin
                wide = {1'b0, opA} + {1'b0, opB};
                carry = wide[cpuPkg::dataWidth];
                overflow = (opA[cpuPkg::wordMsb] == opB[cpuPkg::wordMsb])
                        && (wide[cpuPkg::wordMsb] != opA[cpuPkg::wordMsb]);
            end
            cpuPkg::SUB: begin
                wide = {1'b0, opA} - {1'b0, opB};
                carry = wide[cpuPkg::dataWidth];  // Borrow
                overflow = (opA[cpuPkg::wordMsb] != opB[cpuPkg::wordMsb])
                        && (wide[cpuPkg::wordMsb] != opA[cpuPkg::wordMsb]);
            end
            cpuPkg::AND: wide[cpuPkg::wordMsb:0] = opA & opB;
            cpuPkg::OR: wide[cpuPkg::wordMsb:0] = opA | opB;
            cpuPkg::XOR: wide[cpuPkg::wordMsb:0] = opA ^ opB;
            cpuPkg::SHL: begin
                wide[cpuPkg::wordMsb:0] = opA << 1;  // Shift by one
                carry = opA[cpuPkg::wordMsb];
            end
            cpuPkg::SHR: begin
                wide[cpuPkg::wordMsb:0] = opA >> 1;
                carry = opA[0];
            end
            default: wide[cpuPkg::wordMsb:0] = opB;  // PASSB
        endcase
        aluOut = wide[cpuPkg::wordMsb:0];
    end

    always_comb begin
        res.flagsNew = flags;
        if (ctrl.opClass == cpuPkg::FLAGOP) begin
            res.flagsNew[ctrl.flagIdx] = ctrl.flagValue;
        end else begin
            res.flagsNew[cpuPkg::flagZ] = (aluOut == '0);
            res.flagsNew[cpuPkg::flagN] = aluOut[cpuPkg::wordMsb];
            res.flagsNew[cpuPkg::flagC] = carry;
            res.flagsNew[cpuPkg::flagV] = overflow;
        end
    end

    assign aluClass = (ctrl.opClass == cpuPkg::ATYPE) || (ctrl.opClass == cpuPkg::ITYPE);
    assign taken = (ctrl.opClass == cpuPkg::JTYPE)
                || (ctrl.opClass == cpuPkg::FBRANCH && flags[ctrl.flagIdx] == ctrl.flagValue);

    assign res.result = aluOut;
    assign res.flagsWrite = aluClass || (ctrl.opClass == cpuPkg::FLAGOP);
    assign res.regWrite = aluClass && (ctrl.dest inside {cpuPkg::REGA, cpuPkg::REGB, cpuPkg::REGC});
    assign res.regIdx = ctrl.dest[1:0];  // REGA..REGC encode as 1..3
    assign res.pcNext = pc + 16'd1 + (taken ? ctrl.branchOffset : 16'd0);

endmodule

`default_nettype wire

// File: source/archState.sv
`timescale 1ns/1ps
`default_nettype none

module archState (
    input logic clk,
    input logic rst,
    input logic commit,
    resultBus.state res,
    output cpuPkg::word_t regA,
    output cpuPkg::word_t regB,
    output cpuPkg::word_t regC,
    output cpuPkg::word_t pc,
    output cpuPkg::flags_t flags
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regA <= '0;
            regB <= '0;
            regC <= '0;
            pc <= '0;
            flags <= '0;
        end else if (commit) begin
            pc <= res.pcNext;  // Every legal instruction moves the PC
            if (res.flagsWrite) begin
                flags <= res.flagsNew;
            end
            if (res.regWrite) begin
                case (res.regIdx)
                    2'd1: regA <= res.result;
                    2'd2: regB <= res.result;
                    2'd3: regC <= res.result;
                    default: ;  // Index 0 discards
                endcase
            end
        end
    end

    // One instruction in flight, so commits are always separated by a fetch
    commitSingle: assert property (@(posedge clk) disable iff (rst) commit |=> !commit);

endmodule

`default_nettype wire

// File: source/busSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module busSequencer (
    input logic clk,
    input logic rst,
    ctrlBus.sequencer ctrl,
    resultBus.sequencer res,
    input cpuPkg::word_t pc,
    input cpuPkg::word_t regA,
    output cpuPkg::word_t instr,
    output logic commit,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output cpuPkg::word_t paddr,
    output cpuPkg::word_t pwdata,
    input cpuPkg::word_t prdata,
    input logic pready,
    output logic halted
);

    cpuPkg::cpuState_e state;
    cpuPkg::cpuState_e nextState;
    cpuPkg::word_t storeAddr;
    logic storePhase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpuPkg::START;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = cpuPkg::HALT;
        case (state)
            cpuPkg::START: nextState = cpuPkg::FETCHSETUP;
            cpuPkg::FETCHSETUP: nextState = cpuPkg::FETCHACCESS;
            cpuPkg::FETCHACCESS:
                nextState = pready ? cpuPkg::EXECUTE : cpuPkg::FETCHACCESS;
            cpuPkg::EXECUTE: begin
                if (ctrl.opClass == cpuPkg::ILLEGAL) begin
                    nextState = cpuPkg::HALT;  // Stays until reset
                end else if (ctrl.dest == cpuPkg::STOREA) begin
                    nextState = cpuPkg::STORESETUP;
                end else begin
                    nextState = cpuPkg::FETCHSETUP;
                end
            end
            cpuPkg::STORESETUP: nextState = cpuPkg::STOREACCESS;
            cpuPkg::STOREACCESS:
                nextState = pready ? cpuPkg::FETCHSETUP : cpuPkg::STOREACCESS;
            default: nextState = cpuPkg::HALT;
        endcase
    end

    // Instruction, store address and data registers
    always_ff @(posedge clk) begin
        if (state == cpuPkg::FETCHACCESS && pready) begin
            instr <= prdata;
        end
        if (state == cpuPkg::EXECUTE) begin
            storeAddr <= regA;        // Address before commit
            pwdata <= res.result;
        end
    end

    assign storePhase = (state == cpuPkg::STORESETUP) || (state == cpuPkg::STOREACCESS);
    assign psel = storePhase || (state == cpuPkg::FETCHSETUP) || (state == cpuPkg::FETCHACCESS);
    assign penable = (state == cpuPkg::FETCHACCESS) || (state == cpuPkg::STOREACCESS);
    assign pwrite = storePhase;
    assign paddr = storePhase ? storeAddr : pc;  // PC only changes in EXECUTE
    assign commit = (state == cpuPkg::EXECUTE) && (ctrl.opClass != cpuPkg::ILLEGAL);
    assign halted = (state == cpuPkg::HALT);

    apbEnable: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

    // Address must hold through wait states, including for fetches from PC
    apbAddrHold: assert property (@(posedge clk) disable iff (rst)
        (penable && !pready) |=> $stable(paddr));

endmodule

`default_nettype wire

// File: source/cpuBuses.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlBus;
    cpuPkg::opClass_e opClass;
    cpuPkg::aluOp_e aluOp;
    cpuPkg::regIdx_t srcA;
    cpuPkg::regIdx_t srcB;
    logic useImm;              // Operand B from imm
    cpuPkg::word_t imm;
    cpuPkg::dest_e dest;
    cpuPkg::word_t branchOffset;
    logic [1:0] flagIdx;
    logic flagValue;

    modport decoder (
        output opClass, aluOp, srcA, srcB, useImm, imm, dest,
               branchOffset, flagIdx, flagValue
    );
    modport execute (
        input opClass, aluOp, srcA, srcB, useImm, imm, dest,
              branchOffset, flagIdx, flagValue
    );
    modport sequencer (
        input opClass, dest
    );
endinterface

interface resultBus;
    cpuPkg::word_t result;
    cpuPkg::flags_t flagsNew;
    logic flagsWrite;
    logic regWrite;
    cpuPkg::regIdx_t regIdx;
    cpuPkg::word_t pcNext;

    modport execute (output result, flagsNew, flagsWrite, regWrite, regIdx, pcNext);
    modport state (input result, flagsNew, flagsWrite, regWrite, regIdx, pcNext);
    modport sequencer (input result);  // Store data
endinterface

`default_nettype wire

// File: source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input logic clk,
    input logic rst,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output cpuPkg::word_t paddr,
    output cpuPkg::word_t pwdata,
    input cpuPkg::word_t prdata,
    input logic pready,
    output logic halted
);

    cpuPkg::word_t instr;
    cpuPkg::word_t regA;
    cpuPkg::word_t regB;
    cpuPkg::word_t regC;
    cpuPkg::word_t pc;
    cpuPkg::flags_t flags;
    logic commit;

    ctrlBus ctrlIf ();
    resultBus resIf ();

    busSequencer u_busSequencer (
        .clk(clk), .rst(rst),
        .ctrl(ctrlIf.sequencer), .res(resIf.sequencer),
        .pc(pc), .regA(regA), .instr(instr), .commit(commit),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .halted(halted)
    );

    instrDecoder u_instrDecoder (.instr(instr), .ctrl(ctrlIf.decoder));

    aluExecute u_aluExecute (
        .ctrl(ctrlIf.execute), .res(resIf.execute),
        .regA(regA), .regB(regB), .regC(regC), .pc(pc), .flags(flags)
    );

    archState u_archState (
        .clk(clk), .rst(rst), .commit(commit), .res(resIf.state),
        .regA(regA), .regB(regB), .regC(regC), .pc(pc), .flags(flags)
    );

endmodule

`default_nettype wire

// File: source/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 16;
    localparam int wordMsb = dataWidth - 1;

    typedef logic [wordMsb:0] word_t;
    typedef logic [3:0] flags_t;
    typedef logic [1:0] regIdx_t;  // 0 reads as zero, 1..3 are A, B, C

    // Flag register bit positions
    localparam int flagZ = 0;
    localparam int flagN = 1;
    localparam int flagC = 2;
    localparam int flagV = 3;

    // Instruction field positions
    localparam int srcLsb = 9;       // Source register, A and I types
    localparam int guardBit = 11;    // Must be zero in A and I types
    localparam int aluOpLsb = 5;     // A-type op, low three bits
    localparam int aluOpHiBit = 8;   // A-type op values 8 and up are illegal
    localparam int regBLsb = 3;
    localparam int destLsb = 0;
    localparam int iOpLsb = 12;
    localparam int immMsb = 7;
    localparam int flagIdxLsb = 8;
    localparam int flagValBit = 10;
    localparam int flagModeBit = 11; // Set or clear, else branch
    localparam int jOffMsb = 14;
    localparam int fOffMsb = 7;

    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, SHL, SHR, PASSB
    } aluOp_e;

    typedef enum logic [2:0] {
        NONE, REGA, REGB, REGC, STOREA
    } dest_e;

    typedef enum logic [2:0] {
        ATYPE, ITYPE, JTYPE, FLAGOP, FBRANCH, ILLEGAL
    } opClass_e;

    typedef enum logic [2:0] {
        START, FETCHSETUP, FETCHACCESS, EXECUTE, STORESETUP, STOREACCESS, HALT
    } cpuState_e;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input cpuPkg::word_t instr,
    ctrlBus.decoder ctrl
);

    always_comb begin
        // Defaults, most fields sit at fixed positions
        ctrl.opClass = cpuPkg::ILLEGAL;
        ctrl.aluOp = cpuPkg::ADD;
        ctrl.srcA = instr[cpuPkg::srcLsb +: 2];
        ctrl.srcB = instr[cpuPkg::regBLsb +: 2];
        ctrl.useImm = 1'b0;
        ctrl.imm = {8'h00, instr[cpuPkg::immMsb:0]};  // Zero-extended
        ctrl.dest = cpuPkg::NONE;
        ctrl.branchOffset = {{8{instr[cpuPkg::fOffMsb]}}, instr[cpuPkg::fOffMsb:0]};
        ctrl.flagIdx = instr[cpuPkg::flagIdxLsb +: 2];
        ctrl.flagValue = instr[cpuPkg::flagValBit];

        if (instr[15]) begin
            ctrl.opClass = cpuPkg::JTYPE;
            ctrl.branchOffset = {instr[cpuPkg::jOffMsb], instr[cpuPkg::jOffMsb:0]};
        end else if (instr[15:14] == 2'b01) begin
            if (!instr[cpuPkg::guardBit]) begin
                ctrl.opClass = cpuPkg::ITYPE;
                ctrl.aluOp = cpuPkg::aluOp_e'({1'b0, instr[cpuPkg::iOpLsb +: 2]});
                ctrl.useImm = 1'b1;
                // Same register as source and destination, index 0 discards
                ctrl.dest = cpuPkg::dest_e'({1'b0, instr[cpuPkg::srcLsb +: 2]});
            end
        end else if (instr[15:12] == 4'b0000) begin
            if (!instr[cpuPkg::guardBit] && !instr[cpuPkg::aluOpHiBit]
                    && instr[cpuPkg::destLsb +: 3] <= 3'd4) begin
                ctrl.opClass = cpuPkg::ATYPE;
                ctrl.aluOp = cpuPkg::aluOp_e'(instr[cpuPkg::aluOpLsb +: 3]);
                ctrl.dest = cpuPkg::dest_e'(instr[cpuPkg::destLsb +: 3]);
            end
        end else if (instr[15:12] == 4'b0010) begin
            if (instr[cpuPkg::flagModeBit]) begin
                ctrl.opClass = cpuPkg::FLAGOP;    // Set or clear one flag
            end else begin
                ctrl.opClass = cpuPkg::FBRANCH;   // Branch on one flag
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/cpuModel.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [15:0] mRegs [0:3];  // Index 0 stays zero
logic [15:0] mPc;
logic [3:0] mFlags;
int mSteps;

// 32-bit xorshift, one step per call
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic modelReset();
    for (int i = 0; i < 4; i++) begin
        mRegs[i] = '0;
    end
    mPc = '0;
    mFlags = '0;
    mSteps = 0;
endtask

task automatic aluModel(input logic [2:0] op, input logic [15:0] a, input logic [15:0] b,
                        output logic [15:0] res, output logic [3:0] fl);
    int ua;
    int ub;
    int sa;
    int sb;
    int full;
    ua = a;
    ub = b;
    sa = $signed(a);
    sb = $signed(b);
    fl = '0;
    case (op)
        3'd0: begin
            full = ua + ub;
            fl[cpuPkg::flagC] = full > 65535;
            fl[cpuPkg::flagV] = (sa + sb > 32767) || (sa + sb < -32768);
        end
        3'd1: begin
            full = ua - ub;
            fl[cpuPkg::flagC] = ua < ub;  // Borrow
            fl[cpuPkg::flagV] = (sa - sb > 32767) || (sa - sb < -32768);
        end
        3'd2: full = ua & ub;
        3'd3: full = ua | ub;
        3'd4: full = ua ^ ub;
        3'd5: begin
            full = ua << 1;
            fl[cpuPkg::flagC] = a[15];
        end
        3'd6: begin
            full = ua >> 1;
            fl[cpuPkg::flagC] = a[0];
        end
        default: full = ub;  // Pass B
    endcase
    res = full[15:0];
    fl[cpuPkg::flagZ] = (res == 16'h0000);
    fl[cpuPkg::flagN] = res[15];
endtask

task automatic modelStep(input logic [15:0] ins, output logic illegal, output logic store,
                         output logic [15:0] stAddr, output logic [15:0] stData);
    logic [15:0] res;
    logic [3:0] fl;
    illegal = 1'b0;
    store = 1'b0;
    stAddr = '0;
    stData = '0;
    mSteps++;
    if (ins[15]) begin
        mPc = mPc + 16'd1 + {ins[14], ins[14:0]};  // Jump
    end else if (ins[15:14] == 2'b01 && !ins[11]) begin
        aluModel({1'b0, ins[13:12]}, mRegs[ins[10:9]], {8'h00, ins[7:0]}, res, fl);
        if (ins[10:9] != 2'd0) begin
            mRegs[ins[10:9]] = res;
        end
        mFlags = fl;
        mPc = mPc + 16'd1;
    end else if (ins[15:12] == 4'h0 && !ins[11] && !ins[8] && ins[2:0] <= 3'd4) begin
        aluModel(ins[7:5], mRegs[ins[10:9]], mRegs[ins[4:3]], res, fl);
        mFlags = fl;
        if (ins[2:0] == 3'd4) begin
            store = 1'b1;
            stAddr = mRegs[1];  // Address from A
            stData = res;
        end else if (ins[1:0] != 2'd0) begin
            mRegs[ins[1:0]] = res;
        end
        mPc = mPc + 16'd1;
    end else if (ins[15:12] == 4'h2) begin
        if (ins[11]) begin
            mFlags[ins[9:8]] = ins[10];
            mPc = mPc + 16'd1;
        end else if (mFlags[ins[9:8]] == ins[10]) begin
            mPc = mPc + 16'd1 + {{8{ins[7]}}, ins[7:0]};
        end else begin
            mPc = mPc + 16'd1;
        end
    end else begin
        illegal = 1'b1;
    end
endtask

`endif

// File: tb/tb_cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpuCore;

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [15:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic pready;
    logic halted;

    `include "cpuModel.svh"

    localparam int progLen = 151;  // 150 random words and the halt word
    logic [15:0] prog [0:progLen-1];
    logic [31:0] rng;
    int fetchSeen = 0;

    cpuCore u_cpuCore (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .halted(halted)
    );

    always #2 clk = ~clk;

    // Fetch setup cycles, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && psel && !penable && !pwrite) begin
            fetchSeen++;
        end
    end

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("FAIL at %0t: %s is %0h, expected %0h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int randBelow(input int n);
        rng = xorshift32(rng);
        return int'(rng % n);
    endfunction

    function automatic logic [15:0] readMem(input logic [15:0] addr);
        if (addr < progLen) begin
            return prog[addr];
        end
        return 16'h3000;  // Illegal word everywhere else
    endfunction

    task automatic genProgram();
        int kind;
        logic [1:0] regX;
        logic [1:0] regY;
        logic [2:0] op;
        logic [2:0] dst;
        logic [7:0] imm;
        logic [1:0] off;
        logic [1:0] flag;
        logic val;
        for (int i = 0; i < progLen - 1; i++) begin
            kind = randBelow(8);
            regX = 2'(randBelow(4));
            regY = 2'(randBelow(4));
            op = 3'(randBelow(8));
            dst = 3'(randBelow(5));
            imm = 8'(randBelow(256));
            off = 2'(randBelow(4));
            flag = 2'(randBelow(4));
            val = 1'(randBelow(2));
            case (kind)
                0, 1, 2: prog[i] = {5'b00000, regX, 1'b0, op, regY, dst};  // A-type
                3, 4: prog[i] = {2'b01, op[1:0], 1'b0, regX, 1'b0, imm};
                5: prog[i] = {1'b1, 13'd0, off};
                6: prog[i] = {4'b0010, 1'b1, val, flag, 8'h00};  // Set or clear
                default: prog[i] = {4'b0010, 1'b0, val, flag, 6'd0, off};
            endcase
        end
        prog[progLen-1] = 16'h3000;
    endtask

    // One APB transfer seen from the completer side, with random waits
    task automatic apbTransfer(output logic isWrite, output logic [15:0] addr,
                               output logic [15:0] data);
        int waits;
        int guard;
        guard = 0;
        while (psel !== 1'b1) begin
            if (guard >= 20) begin
                reportFailure("Timeout: no APB transfer started within 20 cycles");
            end
            guard++;
            nextCycle();
        end
        checkValue("penable in setup", penable, 0);
        isWrite = pwrite;
        addr = paddr;
        data = pwdata;
        waits = randBelow(3);
        nextCycle();
        for (int i = 0; i <= waits; i++) begin
            checkValue("psel in access", psel, 1);
            checkValue("penable in access", penable, 1);
            checkValue("paddr held", paddr, addr);
            checkValue("pwrite held", pwrite, isWrite);
            if (isWrite) begin
                checkValue("pwdata held", pwdata, data);
            end
            if (i == waits) begin
                pready = 1'b1;
                prdata = isWrite ? 16'h0000 : readMem(addr);
            end
            nextCycle();
        end
        pready = 1'b0;
        if (isWrite) begin
            $display("APB write addr %h data %h", addr, data);
        end
    endtask

    initial begin
        logic isWrite;
        logic [15:0] addr;
        logic [15:0] data;
        logic illegal;
        logic store;
        logic [15:0] stAddr;
        logic [15:0] stData;
        int guard;
        clk = 1'b0;
        rst = 1'b1;
        prdata = '0;
        pready = 1'b0;
        rng = 32'd47;
        genProgram();
        modelReset();
        repeat (4) @(posedge clk);
        #1;
        checkValue("psel in reset", psel, 0);
        checkValue("penable in reset", penable, 0);
        checkValue("pwrite in reset", pwrite, 0);
        checkValue("halted in reset", halted, 0);
        rst = 1'b0;

        illegal = 1'b0;
        guard = 0;
        while (!illegal) begin
            if (guard >= 400) begin
                reportFailure("Program ran past 400 instructions without halting");
            end
            guard++;
            apbTransfer(isWrite, addr, data);
            checkValue("pwrite on fetch", isWrite, 0);
            checkValue("fetch paddr", addr, mPc);  // First one must be zero
            modelStep(readMem(addr), illegal, store, stAddr, stData);
            if (store) begin
                apbTransfer(isWrite, addr, data);
                checkValue("pwrite on store", isWrite, 1);
                checkValue("store paddr", addr, stAddr);
                checkValue("store pwdata", data, stData);
            end
        end

        guard = 0;
        while (halted !== 1'b1) begin
            if (guard >= 10) begin
                reportFailure("Timeout: halted did not rise after the illegal instruction");
            end
            guard++;
            nextCycle();
        end
        for (int i = 0; i < 20; i++) begin
            checkValue("psel after halt", psel, 0);
            checkValue("halted", halted, 1);
            nextCycle();
        end
        checkValue("fetch count", fetchSeen, mSteps);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
source/cpuPkg.sv
source/cpuBuses.sv
source/instrDecoder.sv
source/aluExecute.sv
source/archState.sv
source/busSequencer.sv
source/cpuCore.sv
tb/tb_cpuCore.sv
